/* Makefile */
VERILATOR  ?= verilator
TOP        := ifu_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/ifu_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module ifu_fsm (
  input  wire  clk,
  input  wire  rst,

  // write-back side.
  input  wire  valid_pre_i,
  output logic ready_pre_o,

  // decode side.
  output logic valid_post_o,
  input  wire  ready_post_i,

  // read address request.
  output logic arvalid_o,
  input  wire  arready_i,

  // read data return.
  input  wire  rvalid_i,
  output logic rready_o,

  // load strobe for the fetch pc.
  output logic we_o
);

  // one fetch at a time, so four states cover the whole sequence.
  typedef enum logic [1:0] {
    idle         = 2'b00,
    wait_arready = 2'b01,
    wait_rvalid  = 2'b10,
    wait_ready   = 2'b11
  } state_t;

  state_t cur_state;
  state_t next_state;

  // every handshake level is a plain decode of the current state.
  assign ready_pre_o  = (cur_state == idle);
  assign arvalid_o    = (cur_state == wait_arready);
  assign rready_o     = (cur_state == wait_rvalid);
  assign valid_post_o = (cur_state == wait_ready);

  // a new pc is taken in the same cycle it is offered while idle.
  assign we_o = ready_pre_o && valid_pre_i;

  // state register.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cur_state <= idle;
    end else begin
      cur_state <= next_state;
    end
  end

  // advance once per handshake, in channel order.
  always_comb begin
    next_state = cur_state;
    case (cur_state)
      idle: begin
        if (valid_pre_i) begin
          next_state = wait_arready;
        end
      end
      // arvalid is high here, so arready alone completes the handshake.
      wait_arready: begin
        if (arready_i) begin
          next_state = wait_rvalid;
        end
      end
      // likewise rready is high while waiting for data.
      wait_rvalid: begin
        if (rvalid_i) begin
          next_state = wait_ready;
        end
      end
      // hold the word until decode takes it.
      wait_ready: begin
        if (ready_post_i) begin
          next_state = idle;
        end
      end
      default: next_state = idle;
    endcase
  end

endmodule

`default_nettype wire

/* design/ifu_inst_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module ifu_inst_buf (
  input  wire                              clk,
  input  wire                              rst,

  // pc load from the write-back handshake.
  input  wire                              we_i,
  input  wire  [ifu_pkg::XLEN-1:0]         next_pc_i,

  // read data channel, observed alongside the controller.
  input  wire                              rvalid_i,
  input  wire                              rready_i,
  input  wire  [ifu_pkg::INST_W-1:0]       rdata_i,
  input  wire  [ifu_pkg::RESP_W-1:0]       rresp_i,

  // held pc, used as the read address.
  output logic [ifu_pkg::XLEN-1:0]         fetch_pc_o,

  // payload toward decode.
  output logic [ifu_pkg::INST_W-1:0]       inst_o,
  output logic [ifu_pkg::XLEN-1:0]         inst_pc_o,
  output logic                             inst_fault_o
);

  import ifu_pkg::*;

  logic r_hs;

  // data is taken on the same edge the controller sees it.
  assign r_hs = rvalid_i && rready_i;

  // fetch pc.
  // stays put from one acceptance to the next.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      fetch_pc_o <= '0;
    end else if (we_i) begin
      fetch_pc_o <= next_pc_i;
    end
  end

  // decode payload.
  // the pc travels with its word so decode sees a matched pair.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      inst_o       <= '0;
      inst_pc_o    <= '0;
      inst_fault_o <= 1'b0;
    end else if (r_hs) begin
      inst_o       <= rdata_i;
      inst_pc_o    <= fetch_pc_o;
      // any response other than okay marks the word as faulted.
      inst_fault_o <= (rresp_i != RESP_OKAY);
    end
  end

endmodule

`default_nettype wire

/* design/ifu_pkg.sv */
`default_nettype none

package ifu_pkg;

  // width of the pc and of the read address.
  localparam int XLEN = 32;

  // width of one instruction word.
  localparam int INST_W = 32;

  // instruction memory geometry, in words.
  localparam int ROM_DEPTH = 16;
  localparam int ROM_AW    = 4;

  // byte address that maps to word zero.
  localparam logic [XLEN-1:0] ROM_BASE = 32'h8000_0000;

  // cycles from first arvalid to arready.
  localparam int AR_WAIT = 1;
  // cycles from the address handshake to rvalid.
  localparam int R_WAIT  = 2;
  // width of the wait-state counters, wide enough for either wait.
  localparam int WAIT_CW = 4;

  // read response codes.
  localparam int RESP_W = 2;
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

  // memory image, relative to the directory the simulator runs in.
  localparam string ROM_FILE = "design/inst_rom.hex";

endpackage

`default_nettype wire

/* design/ifu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ifu_top (
  input  wire                              clk,
  input  wire                              rst,

  // write-back side.
  input  wire                              valid_pre_i,
  input  wire  [ifu_pkg::XLEN-1:0]         next_pc_i,
  output logic                             ready_pre_o,

  // decode side.
  output logic                             valid_post_o,
  input  wire                              ready_post_i,
  output logic [ifu_pkg::INST_W-1:0]       inst_o,
  output logic [ifu_pkg::XLEN-1:0]         inst_pc_o,
  output logic                             inst_fault_o
);

  import ifu_pkg::*;

  // read channel between controller and memory.
  logic              arvalid;
  logic              arready;
  logic              rvalid;
  logic              rready;
  logic [INST_W-1:0] rdata;
  logic [RESP_W-1:0] rresp;

  // pc load strobe and the held fetch address.
  logic              we;
  logic [XLEN-1:0]   fetch_pc;

  // controller owns both stage handshakes.
  ifu_fsm ifu_fsm_inst (
    .clk          (clk),
    .rst          (rst),
    .valid_pre_i  (valid_pre_i),
    .ready_pre_o  (ready_pre_o),
    .valid_post_o (valid_post_o),
    .ready_post_i (ready_post_i),
    .arvalid_o    (arvalid),
    .arready_i    (arready),
    .rvalid_i     (rvalid),
    .rready_o     (rready),
    .we_o         (we)
  );

  // instruction memory.
  // the buffered pc is the read address.
  inst_rom inst_rom_inst (
    .clk       (clk),
    .rst       (rst),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (fetch_pc),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .rdata_o   (rdata),
    .rresp_o   (rresp)
  );

  // buffer toward decode.
  ifu_inst_buf ifu_inst_buf_inst (
    .clk          (clk),
    .rst          (rst),
    .we_i         (we),
    .next_pc_i    (next_pc_i),
    .rvalid_i     (rvalid),
    .rready_i     (rready),
    .rdata_i      (rdata),
    .rresp_i      (rresp),
    .fetch_pc_o   (fetch_pc),
    .inst_o       (inst_o),
    .inst_pc_o    (inst_pc_o),
    .inst_fault_o (inst_fault_o)
  );

endmodule

`default_nettype wire

/* design/inst_rom.hex */
// one 32-bit instruction word per line in hex, the first line is the word at ROM_BASE.
00500093
00a00113
002081b3
40208233
0020f2b3
0020e333
0020c3b3
00209433
0020d4b3
00302023
00002503
00208463
00c000ef
fff08093
fe0098e3
00008067

/* design/inst_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_rom (
  input  wire                              clk,
  input  wire                              rst,

  // address request.
  input  wire                              arvalid_i,
  output logic                             arready_o,
  input  wire  [ifu_pkg::XLEN-1:0]         araddr_i,

  // data return.
  output logic                             rvalid_o,
  input  wire                              rready_i,
  output logic [ifu_pkg::INST_W-1:0]       rdata_o,
  output logic [ifu_pkg::RESP_W-1:0]       rresp_o
);

  import ifu_pkg::*;

  logic [INST_W-1:0]  mem [ROM_DEPTH];

  logic [WAIT_CW-1:0] ar_cnt;
  logic [WAIT_CW-1:0] r_cnt;
  logic               r_busy;
  logic [XLEN-1:0]    offset;
  logic [ROM_AW-1:0]  index;
  logic               addr_ok;
  logic               ar_hs;
  logic               r_hs;

  // contents come from the hex image.
  initial begin
    $readmemh(ROM_FILE, mem);
  end

  // an address below the base wraps to a large offset and fails the range check.
  assign offset  = araddr_i - ROM_BASE;
  assign index   = offset[ROM_AW+1:2];
  assign addr_ok = (araddr_i[1:0] == 2'b00) && (offset < XLEN'(ROM_DEPTH * 4));

  assign ar_hs = arvalid_i && arready_o;
  assign r_hs  = rvalid_o && rready_i;

  // address wait states.
  // arready is held off while a read is still outstanding.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      arready_o <= 1'b0;
      ar_cnt    <= '0;
    end else if (ar_hs) begin
      arready_o <= 1'b0;
      ar_cnt    <= '0;
    end else if (arvalid_i && !arready_o && !r_busy) begin
      if (ar_cnt == WAIT_CW'(AR_WAIT - 1)) begin
        arready_o <= 1'b1;
      end else begin
        ar_cnt <= ar_cnt + 1'b1;
      end
    end
  end

  // data wait states.
  // rvalid holds until the requester takes the word.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      r_busy   <= 1'b0;
      r_cnt    <= '0;
      rvalid_o <= 1'b0;
    end else if (ar_hs) begin
      r_busy <= 1'b1;
      r_cnt  <= '0;
    end else if (r_hs) begin
      r_busy   <= 1'b0;
      rvalid_o <= 1'b0;
    end else if (r_busy && !rvalid_o) begin
      if (r_cnt == WAIT_CW'(R_WAIT - 1)) begin
        rvalid_o <= 1'b1;
      end else begin
        r_cnt <= r_cnt + 1'b1;
      end
    end
  end

  // word and response are fixed at address acceptance.
  // a bad address returns zero data.
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rdata_o <= addr_ok ? mem[index] : '0;
      rresp_o <= addr_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

`default_nettype wire

/* dv/ifu_tb_table.svh */
`ifndef IFU_TB_TABLE_SVH
`define IFU_TB_TABLE_SVH

  // columns are test name, fetch pc, ready_post_i hold cycles, random hold, idle gap first.
  // a random hold ignores the fixed count.
  task automatic build_table();
    add_entry("word_00",       32'h8000_0000, 0, 1'b0, 1'b1);
    add_entry("word_01",       32'h8000_0004, 0, 1'b0, 1'b0);
    add_entry("word_02",       32'h8000_0008, 0, 1'b0, 1'b0);
    add_entry("word_03",       32'h8000_000c, 2, 1'b0, 1'b0);
    add_entry("word_04",       32'h8000_0010, 0, 1'b0, 1'b1);
    add_entry("word_05",       32'h8000_0014, 0, 1'b1, 1'b0);
    add_entry("word_06",       32'h8000_0018, 4, 1'b0, 1'b0);
    add_entry("word_07",       32'h8000_001c, 0, 1'b0, 1'b0);
    add_entry("word_08",       32'h8000_0020, 1, 1'b0, 1'b1);
    add_entry("word_09",       32'h8000_0024, 0, 1'b1, 1'b0);
    add_entry("word_10",       32'h8000_0028, 0, 1'b0, 1'b0);
    add_entry("word_11",       32'h8000_002c, 3, 1'b0, 1'b0);
    // faulting fetches, then a clean fetch to show recovery.
    add_entry("misaligned",    32'h8000_0006, 2, 1'b0, 1'b0);
    add_entry("past_end",      32'h8000_0040, 0, 1'b0, 1'b0);
    add_entry("below_base",    32'h7fff_fffc, 0, 1'b1, 1'b1);
    add_entry("word_12",       32'h8000_0030, 0, 1'b0, 1'b0);
    add_entry("word_13",       32'h8000_0034, 0, 1'b1, 1'b1);
    add_entry("word_14",       32'h8000_0038, 0, 1'b0, 1'b0);
    add_entry("word_15",       32'h8000_003c, 5, 1'b0, 1'b0);
    add_entry("misaligned_hi", 32'h8000_003d, 0, 1'b0, 1'b0);
  endtask

`endif

/* dv/ifu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ifu_tb;

  import ifu_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int GAP_CYCLES   = 3;
  // longest wait for one handshake before giving up.
  localparam int WAIT_LIMIT   = 16;
  // generous cycle budget for one table entry.
  localparam int FETCH_BOUND  = 24;

  logic              clk;
  logic              rst;
  logic              valid_pre;
  logic [XLEN-1:0]   next_pc;
  logic              ready_pre;
  logic              valid_post;
  logic              ready_post;
  logic [INST_W-1:0] inst;
  logic [XLEN-1:0]   inst_pc;
  logic              inst_fault;

  // reference copy of the memory image.
  logic [INST_W-1:0] ref_mem [ROM_DEPTH];

  // stimulus table with one slot per entry.
  string             name_q[$];
  logic [XLEN-1:0]   pc_q[$];
  int                hold_q[$];
  bit                rnd_q[$];
  bit                gap_q[$];

  int                check_cnt;
  int                value_err_cnt;
  int                proto_err_cnt;
  bit                table_built;
  bit                aborted;

  ifu_top ifu_top_inst (
    .clk          (clk),
    .rst          (rst),
    .valid_pre_i  (valid_pre),
    .next_pc_i    (next_pc),
    .ready_pre_o  (ready_pre),
    .valid_post_o (valid_post),
    .ready_post_i (ready_post),
    .inst_o       (inst),
    .inst_pc_o    (inst_pc),
    .inst_fault_o (inst_fault)
  );

  task automatic add_entry(input string name, input logic [XLEN-1:0] pc, input int hold,
                           input bit rnd, input bit gap);
    name_q.push_back(name);
    pc_q.push_back(pc);
    hold_q.push_back(hold);
    rnd_q.push_back(rnd);
    gap_q.push_back(gap);
  endtask

  `include "ifu_tb_table.svh"

  // a good read is word aligned and lies inside the sixteen words above the base.
  function automatic bit pc_is_good(input logic [XLEN-1:0] pc);
    return (pc[1:0] == 2'b00) && (pc >= ROM_BASE) &&
           (pc < ROM_BASE + XLEN'(ROM_DEPTH * 4));
  endfunction

  // bad reads return zero data.
  function automatic logic [INST_W-1:0] expected_word(input logic [XLEN-1:0] pc);
    logic [XLEN-1:0] word_idx;
    word_idx = (pc - ROM_BASE) >> 2;
    return pc_is_good(pc) ? ref_mem[word_idx[ROM_AW-1:0]] : '0;
  endfunction

  task automatic check_value(input string test, input string field,
                             input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
    check_cnt++;
    assert (act === exp) else begin
      value_err_cnt++;
      $display("error %s %s expected %h actual %h", test, field, exp, act);
    end
  endtask

  task automatic check_rule(input bit cond, input string test, input string what);
    check_cnt++;
    assert (cond) else begin
      proto_err_cnt++;
      $display("%s: %s", test, what);
    end
  endtask

  // one table entry from request to decode acceptance.
  task automatic run_fetch(input int idx);
    string             test;
    logic [XLEN-1:0]   pc;
    logic [INST_W-1:0] held_inst;
    logic [XLEN-1:0]   held_pc;
    int                hold;
    int                waited;
    test = name_q[idx];
    pc   = pc_q[idx];
    hold = rnd_q[idx] ? int'($urandom % 5) + 1 : hold_q[idx];
    if (gap_q[idx]) begin
      valid_pre = 1'b0;
      repeat (GAP_CYCLES) begin
        @(posedge clk);
        #1;
        check_rule(!valid_post, test, "valid_post_o rose with no fetch pending");
      end
    end
    // decode is ready up front unless this entry holds it back.
    ready_post = (hold == 0);
    valid_pre  = 1'b1;
    next_pc    = pc;
    waited     = 0;
    while (!ready_pre && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    check_rule(ready_pre, test, "ready_pre_o never rose to accept the pc");
    if (!ready_pre) begin
      aborted = 1'b1;
      return;
    end
    @(posedge clk);
    #1;
    // scramble next_pc so a wrong held pc shows up.
    valid_pre = 1'b0;
    next_pc   = ~pc;
    check_rule(!ready_pre, test, "ready_pre_o stayed high after the pc was accepted");
    waited = 0;
    while (!valid_post && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    check_rule(valid_post, test, "valid_post_o never rose after the pc was accepted");
    if (!valid_post) begin
      aborted = 1'b1;
      return;
    end
    // under back-pressure the word must sit still.
    held_inst = inst;
    held_pc   = inst_pc;
    repeat (hold) begin
      @(posedge clk);
      #1;
      check_rule(valid_post, test, "valid_post_o dropped while ready_post_i was low");
      check_rule(!ready_pre, test, "ready_pre_o rose while a word waited for decode");
      check_value(test, "held inst_o", XLEN'(held_inst), XLEN'(inst));
      check_value(test, "held inst_pc_o", held_pc, inst_pc);
    end
    // these values are what the consuming edge hands to decode.
    ready_post = 1'b1;
    check_value(test, "inst_o", XLEN'(expected_word(pc)), XLEN'(inst));
    check_value(test, "inst_pc_o", pc, inst_pc);
    check_value(test, "inst_fault_o", XLEN'(!pc_is_good(pc)), XLEN'(inst_fault));
    @(posedge clk);
    #1;
    check_rule(!valid_post, test, "valid_post_o stayed high after decode took the word");
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst        = 1'b0;
    valid_pre  = 1'b0;
    next_pc    = '0;
    ready_post = 1'b0;
    void'($urandom(32'h71ed2d66));
    $readmemh(ROM_FILE, ref_mem);
    build_table();
    table_built = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b1;
    @(posedge clk);
    #1;
    // idle state straight out of reset.
    check_value("reset", "ready_pre_o", XLEN'(1), XLEN'(ready_pre));
    check_value("reset", "valid_post_o", XLEN'(0), XLEN'(valid_post));
    check_value("reset", "inst_o", XLEN'(0), XLEN'(inst));
    check_value("reset", "inst_pc_o", XLEN'(0), inst_pc);
    check_value("reset", "inst_fault_o", XLEN'(0), XLEN'(inst_fault));
    for (int i = 0; i < name_q.size() && !aborted; i++) begin
      run_fetch(i);
    end
    ready_post = 1'b0;
    repeat (2) @(posedge clk);
    $display("checks %0d, value errors %0d, protocol errors %0d",
             check_cnt, value_err_cnt, proto_err_cnt);
    if (value_err_cnt + proto_err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog sized from the table length.
  initial begin
    wait (table_built);
    #((name_q.size() * FETCH_BOUND + RESET_CYCLES + 4) * CLK_PERIOD);
    $display("watchdog expired before the fetch sequence completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+dv
design/ifu_pkg.sv
design/ifu_fsm.sv
design/inst_rom.sv
design/ifu_inst_buf.sv
design/ifu_top.sv
dv/ifu_tb.sv
